/* design/stm_pkg.sv */
// Shared table memory package
// Table geometry, read and write address fields, chunk and payload types
// and the per-port read response struct

package stm_pkg;

    // Table geometry
    localparam int STM_BANKS   = 4;     // Banks in the table
    localparam int STM_CHUNKS  = 4;     // Chunks per row, the rotation is built on 4
    localparam int STM_CHUNK_W = 16;    // Bits per chunk
    localparam int STM_ROWS    = 64;    // Rows per chunk memory

    // Read ports: 0 and 2 are LPM, 1 and 3 are EM
    // Client 0 owns ports 0/1, client 1 owns ports 2/3
    localparam int STM_RPORTS  = 4;

    // Read address fields, from MSB down: bank, row, start chunk
    localparam int STM_BANK_W   = 2;
    localparam int STM_ROW_W    = 6;
    localparam int STM_START_W  = 2;
    localparam int STM_ROW_LSB  = STM_START_W;              // Row sits above start
    localparam int STM_BANK_LSB = STM_START_W + STM_ROW_W;  // Bank on top
    localparam int STM_ADDR_W   = STM_BANK_W + STM_ROW_W + STM_START_W;   // 10 bits

    // Write address carries bank and row only, no start chunk
    localparam int STM_WADDR_W  = STM_BANK_W + STM_ROW_W;   // 8 bits

    // One chunk of table data
    typedef logic [STM_CHUNK_W-1:0] chunk_t;

    // Full row, element 0 at the LSB end
    typedef chunk_t [STM_CHUNKS-1:0] row_data_t;

    // LPM lookup returns 2 chunks
    typedef chunk_t [1:0] lpm_data_t;

    // EM lookup returns all 4 chunks
    typedef chunk_t [STM_CHUNKS-1:0] em_data_t;

    // Raw read response of one port, before rotation
    typedef struct packed {
        logic                   rvalid;     // Read was issued 2 cycles back
        logic [STM_START_W-1:0] start;      // Start chunk of the entry
        row_data_t              data;       // Chunks in memory order
    } rd_resp_t;

endpackage

/* design/stm_rd_if.sv */
// Decoded read request interface between decode and execute
// One element per read port on every signal

`timescale 1ns/1ps

interface stm_rd_if
    import stm_pkg::*;
#(
    parameter int RPORTS = 4,           // Read ports carried
    parameter int BANKS  = 4,           // Banks in the table
    parameter int ROWS   = 64           // Rows per chunk memory
);

    localparam int BANK_W = $clog2(BANKS);
    localparam int ROW_W  = $clog2(ROWS);

    logic [RPORTS-1:0]                   ren;       // Registered read strobe
    logic [RPORTS-1:0][BANK_W-1:0]       bank;      // Addressed bank
    logic [RPORTS-1:0][ROW_W-1:0]        row_lo;    // Addressed row
    logic [RPORTS-1:0][ROW_W-1:0]        row_hi;    // Next row, wraps to 0
    logic [RPORTS-1:0][STM_START_W-1:0]  start;     // Start chunk

    // Decode side drives everything
    modport dec (
        output ren, bank, row_lo, row_hi, start
    );

    // Execute side only listens
    modport exe (
        input  ren, bank, row_lo, row_hi, start
    );

endinterface

/* design/stm_decode.sv */
// Read request decode stage
// Registers strobe and address per port and splits the address fields

`timescale 1ns/1ps

module stm_decode
    import stm_pkg::*;
#(
    parameter int BANKS  = STM_BANKS,   // Banks in the table
    parameter int ROWS   = STM_ROWS,    // Rows per chunk memory
    parameter int RPORTS = STM_RPORTS   // Read ports
)
(
    input  logic                                cclk,
    input  logic                                i_reset,

    input  logic [RPORTS-1:0]                   i_ren,      // Per port read strobe
    input  logic [RPORTS-1:0][STM_ADDR_W-1:0]   i_raddr,    // Per port read address

    stm_rd_if.dec                               rd
);

    localparam int BANK_W = $clog2(BANKS);
    localparam int ROW_W  = $clog2(ROWS);

    logic [RPORTS-1:0]                  ren_q;      // Strobe after edge 1
    logic [RPORTS-1:0][STM_ADDR_W-1:0]  raddr_q;    // Address after edge 1

    // Strobes are control state, cleared on reset
    always_ff @(posedge cclk) begin
        if (i_reset) begin
            ren_q <= '0;
        end else begin
            ren_q <= i_ren;
        end
    end

    // Address only loads on a strobe
    always_ff @(posedge cclk) begin
        for (int p = 0; p < RPORTS; p++) begin
            if (i_ren[p]) begin
                raddr_q[p] <= i_raddr[p];
            end
        end
    end

    // Field split and next-row calculation
    always_comb begin
        logic [ROW_W-1:0] row;                      // Row field of current port
        row = '0;
        for (int p = 0; p < RPORTS; p++) begin
            row          = raddr_q[p][STM_ROW_LSB +: ROW_W];
            rd.ren[p]    = ren_q[p];
            rd.bank[p]   = raddr_q[p][STM_BANK_LSB +: BANK_W];
            rd.start[p]  = raddr_q[p][0 +: STM_START_W];
            rd.row_lo[p] = row;

            // Entries that start late spill into the next row
            if (row == ROW_W'(ROWS - 1)) begin
                rd.row_hi[p] = '0;                  // Last row wraps to row 0
            end else begin
                rd.row_hi[p] = row + 1'b1;
            end
        end
    end

endmodule

/* design/stm_execute.sv */
// Table memory execute stage
// Bank and chunk register arrays, masked config write port
// and registered per-port chunk reads

`timescale 1ns/1ps

module stm_execute
    import stm_pkg::*;
#(
    parameter int BANKS  = STM_BANKS,   // Banks in the table
    parameter int ROWS   = STM_ROWS,    // Rows per chunk memory
    parameter int RPORTS = STM_RPORTS   // Read ports
)
(
    input  logic                        cclk,
    input  logic                        i_reset,

    stm_rd_if.exe                       rd,             // Decoded read requests

    input  logic                        i_wen,          // Config write strobe
    input  logic [STM_WADDR_W-1:0]      i_waddr,        // Bank and row
    input  logic [STM_CHUNKS-1:0]       i_wmask,        // Per chunk write enable
    input  row_data_t                   i_wdata,        // Full row of write data

    output rd_resp_t [RPORTS-1:0]       o_resp          // Raw chunks per port
);

    localparam int BANK_W = $clog2(BANKS);
    localparam int ROW_W  = $clog2(ROWS);

    // Table storage, one memory per bank and chunk
    chunk_t mem [BANKS-1:0][STM_CHUNKS-1:0][ROWS-1:0];

    logic [BANK_W-1:0]  wbank;                      // Write bank field
    logic [ROW_W-1:0]   wrow;                       // Write row field

    logic [RPORTS-1:0][STM_CHUNKS-1:0][ROW_W-1:0]  sel_row;   // Row used by each chunk

    logic [RPORTS-1:0]                  rvalid_q;   // Valid after edge 2
    logic [RPORTS-1:0][STM_START_W-1:0] start_q;    // Start chunk carried along
    row_data_t [RPORTS-1:0]             rdata_q;    // Raw chunks in memory order

    assign wbank = i_waddr[STM_ROW_W +: BANK_W];
    assign wrow  = i_waddr[0 +: ROW_W];

    // Masked write, untouched chunks keep their contents
    always_ff @(posedge cclk) begin
        if (i_wen) begin
            for (int c = 0; c < STM_CHUNKS; c++) begin
                if (i_wmask[c]) begin
                    mem[wbank][c][wrow] <= i_wdata[c];
                end
            end
        end
    end

    // Chunks before the start chunk belong to the next row
    always_comb begin
        for (int p = 0; p < RPORTS; p++) begin
            for (int c = 0; c < STM_CHUNKS; c++) begin
                if (STM_START_W'(c) >= rd.start[p]) begin
                    sel_row[p][c] = rd.row_lo[p];
                end else begin
                    sel_row[p][c] = rd.row_hi[p];   // Wrapped part of the entry
                end
            end
        end
    end

    // Valid per port, cleared on reset
    always_ff @(posedge cclk) begin
        if (i_reset) begin
            rvalid_q <= '0;
        end else begin
            rvalid_q <= rd.ren;
        end
    end

    // Every port has its own read path, so no bank arbitration
    always_ff @(posedge cclk) begin
        for (int p = 0; p < RPORTS; p++) begin
            if (rd.ren[p]) begin
                start_q[p] <= rd.start[p];
                for (int c = 0; c < STM_CHUNKS; c++) begin
                    rdata_q[p][c] <= mem[rd.bank[p]][c][sel_row[p][c]];
                end
            end
        end
    end

    // Pack the response structs
    always_comb begin
        for (int p = 0; p < RPORTS; p++) begin
            o_resp[p].rvalid = rvalid_q[p];
            o_resp[p].start  = start_q[p];
            o_resp[p].data   = rdata_q[p];
        end
    end

endmodule

/* design/stm_result.sv */
// Result stage for one read port
// Rotates raw chunks so the start chunk lands at element 0
// and registers the payload with its valid

`timescale 1ns/1ps

module stm_result
    import stm_pkg::*;
#(
    parameter type payload_t = lpm_data_t,  // LPM or EM payload
    parameter int  N_CHUNKS  = 2            // Chunks kept from the rotated row
)
(
    input  logic        cclk,
    input  logic        i_reset,

    input  rd_resp_t    i_resp,             // Raw response from execute

    output logic        o_rvalid,           // Result valid, 3 cycles after request
    output payload_t    o_rdata             // Rotated payload
);

    row_data_t  rot;                        // Row with start chunk at element 0
    payload_t   payload;                    // Low N_CHUNKS elements of rot

    // Element k is chunk (start + k) mod 4, the 2-bit add wraps for free
    always_comb begin
        logic [STM_START_W-1:0] idx;
        idx = '0;
        for (int k = 0; k < STM_CHUNKS; k++) begin
            idx    = i_resp.start + STM_START_W'(k);
            rot[k] = i_resp.data[idx];
        end
    end

    assign payload = payload_t'(rot[N_CHUNKS-1:0]);    // Drop the upper chunks

    always_ff @(posedge cclk) begin
        if (i_reset) begin
            o_rvalid <= 1'b0;
        end else begin
            o_rvalid <= i_resp.rvalid;
        end
    end

    // Payload holds its last value between results
    always_ff @(posedge cclk) begin
        if (i_resp.rvalid) begin
            o_rdata <= payload;
        end
    end

endmodule

/* design/stm_top.sv */
// Shared forwarding table memory top level
// Two lookup clients, each with one LPM and one EM read port,
// plus one masked configuration write port

`timescale 1ns/1ps

module stm_top
    import stm_pkg::*;
#(
    parameter int BANKS = STM_BANKS,    // Banks in the table
    parameter int ROWS  = STM_ROWS      // Rows per chunk memory
)
(
    input  logic                    cclk,
    input  logic                    i_reset,

    // Client 0 LPM port
    input  logic                    i_lpm0_ren,
    input  logic [STM_ADDR_W-1:0]   i_lpm0_raddr,
    output logic                    o_lpm0_rvalid,
    output lpm_data_t               o_lpm0_rdata,

    // Client 0 EM port
    input  logic                    i_em0_ren,
    input  logic [STM_ADDR_W-1:0]   i_em0_raddr,
    output logic                    o_em0_rvalid,
    output em_data_t                o_em0_rdata,

    // Client 1 LPM port
    input  logic                    i_lpm1_ren,
    input  logic [STM_ADDR_W-1:0]   i_lpm1_raddr,
    output logic                    o_lpm1_rvalid,
    output lpm_data_t               o_lpm1_rdata,

    // Client 1 EM port
    input  logic                    i_em1_ren,
    input  logic [STM_ADDR_W-1:0]   i_em1_raddr,
    output logic                    o_em1_rvalid,
    output em_data_t                o_em1_rdata,

    // Configuration write
    input  logic                    i_wen,
    input  logic [STM_WADDR_W-1:0]  i_waddr,
    input  logic [STM_CHUNKS-1:0]   i_wmask,
    input  row_data_t               i_wdata
);

    logic [STM_RPORTS-1:0]                  ren;        // Port order lpm0, em0, lpm1, em1
    logic [STM_RPORTS-1:0][STM_ADDR_W-1:0]  raddr;
    rd_resp_t [STM_RPORTS-1:0]              resp;       // Raw responses from execute

    assign ren = {i_em1_ren, i_lpm1_ren, i_em0_ren, i_lpm0_ren};

    assign raddr[0] = i_lpm0_raddr;
    assign raddr[1] = i_em0_raddr;
    assign raddr[2] = i_lpm1_raddr;
    assign raddr[3] = i_em1_raddr;

    stm_rd_if #(
        .RPORTS (STM_RPORTS),
        .BANKS  (BANKS),
        .ROWS   (ROWS)
    ) rd_if ();

    // Edge 1, request register and address split
    stm_decode #(
        .BANKS  (BANKS),
        .ROWS   (ROWS),
        .RPORTS (STM_RPORTS)
    ) u_decode (
        .cclk       (cclk),
        .i_reset    (i_reset),
        .i_ren      (ren),
        .i_raddr    (raddr),
        .rd         (rd_if.dec)
    );

    // Edge 2, memory read and write
    stm_execute #(
        .BANKS  (BANKS),
        .ROWS   (ROWS),
        .RPORTS (STM_RPORTS)
    ) u_execute (
        .cclk       (cclk),
        .i_reset    (i_reset),
        .rd         (rd_if.exe),
        .i_wen      (i_wen),
        .i_waddr    (i_waddr),
        .i_wmask    (i_wmask),
        .i_wdata    (i_wdata),
        .o_resp     (resp)
    );

    // Edge 3, rotation and output registers
    stm_result #(.payload_t(lpm_data_t), .N_CHUNKS(2)) u_result_lpm0 (
        .cclk       (cclk),
        .i_reset    (i_reset),
        .i_resp     (resp[0]),
        .o_rvalid   (o_lpm0_rvalid),
        .o_rdata    (o_lpm0_rdata)
    );

    stm_result #(.payload_t(em_data_t), .N_CHUNKS(4)) u_result_em0 (
        .cclk       (cclk),
        .i_reset    (i_reset),
        .i_resp     (resp[1]),
        .o_rvalid   (o_em0_rvalid),
        .o_rdata    (o_em0_rdata)
    );

    stm_result #(.payload_t(lpm_data_t), .N_CHUNKS(2)) u_result_lpm1 (
        .cclk       (cclk),
        .i_reset    (i_reset),
        .i_resp     (resp[2]),
        .o_rvalid   (o_lpm1_rvalid),
        .o_rdata    (o_lpm1_rdata)
    );

    stm_result #(.payload_t(em_data_t), .N_CHUNKS(4)) u_result_em1 (
        .cclk       (cclk),
        .i_reset    (i_reset),
        .i_resp     (resp[3]),
        .o_rvalid   (o_em1_rvalid),
        .o_rdata    (o_em1_rdata)
    );

endmodule

/* include/stm_tb_tasks.svh */
// Directed test tasks for the table memory testbench
// Request setup, reference model update, per-cycle drive and result checks

`ifndef STM_TB_TASKS_SVH
`define STM_TB_TASKS_SVH

function automatic row_data_t random_row();
    row_data_t d;
    for (int c = 0; c < STM_CHUNKS; c++) begin
        d[c] = chunk_t'($urandom());
    end
    return d;
endfunction

// Element k is chunk (s+k) mod 4, chunks below s come from the next row
function automatic row_data_t expected_payload(input int p, input logic [STM_ADDR_W-1:0] addr);
    int        bank;
    int        row;
    int        s;
    int        c;
    int        src;
    row_data_t res;
    bank = int'(addr[STM_BANK_LSB +: STM_BANK_W]);
    row  = int'(addr[STM_ROW_LSB +: STM_ROW_W]);
    s    = int'(addr[0 +: STM_START_W]);
    for (int k = 0; k < STM_CHUNKS; k++) begin
        c      = (s + k) % STM_CHUNKS;
        src    = (c >= s) ? row : (row + 1) % STM_ROWS;     // Last row wraps to 0
        res[k] = ref_mem[bank][src][c];
    end
    if (p % 2 == 0) begin   // LPM keeps two chunks
        res[3] = '0;
        res[2] = '0;
    end
    return res;
endfunction

task automatic model_write(input logic [STM_WADDR_W-1:0] waddr,
                           input logic [STM_CHUNKS-1:0] mask, input row_data_t data);
    int bank;
    int row;
    bank = int'(waddr[STM_ROW_W +: STM_BANK_W]);
    row  = int'(waddr[0 +: STM_ROW_W]);
    for (int c = 0; c < STM_CHUNKS; c++) begin
        if (mask[c]) begin
            ref_mem[bank][row][c] = data[c];
        end
    end
endtask

task automatic set_read(input int p, input int bank, input int row, input int start);
    req_ren[p]  = 1'b1;
    req_addr[p] = {STM_BANK_W'(bank), STM_ROW_W'(row), STM_START_W'(start)};
endtask

task automatic set_write(input int bank, input int row, input logic [STM_CHUNKS-1:0] mask,
                         input row_data_t data);
    req_wen   = 1'b1;
    req_waddr = {STM_BANK_W'(bank), STM_ROW_W'(row)};
    req_wmask = mask;
    req_wdata = data;
endtask

task automatic clear_request();
    for (int p = 0; p < STM_RPORTS; p++) begin
        req_ren[p]  = 1'b0;
        req_addr[p] = '0;
    end
    req_wen   = 1'b0;
    req_waddr = '0;
    req_wmask = '0;
    req_wdata = '0;
endtask

task automatic clear_pipeline();
    for (int st = 0; st < 3; st++) begin
        for (int p = 0; p < STM_RPORTS; p++) begin
            exp_vld[st][p] = 1'b0;
            exp_dat[st][p] = '0;
        end
    end
endtask

task automatic drive_inputs();
    i_lpm0_ren   = req_ren[0];
    i_lpm0_raddr = req_addr[0];
    i_em0_ren    = req_ren[1];
    i_em0_raddr  = req_addr[1];
    i_lpm1_ren   = req_ren[2];
    i_lpm1_raddr = req_addr[2];
    i_em1_ren    = req_ren[3];
    i_em1_raddr  = req_addr[3];
    i_wen        = req_wen;
    i_waddr      = req_waddr;
    i_wmask      = req_wmask;
    i_wdata      = req_wdata;
endtask

function automatic string port_name(input int p);
    case (p)
        0:       return "lpm0";
        1:       return "em0";
        2:       return "lpm1";
        default: return "em1";
    endcase
endfunction

// Valid every cycle, data only when a result is due
task automatic check_port(input int p);
    checks++;
    if (dut_rvalid[p] !== exp_vld[2][p]) begin
        errors++;
        $display("** Error at %0t: o_%s_rvalid = %b, expected %b",
                 $time, port_name(p), dut_rvalid[p], exp_vld[2][p]);
    end
    if (exp_vld[2][p]) begin
        checks++;
        if (dut_rdata[p] !== exp_dat[2][p]) begin
            errors++;
            $display("** Error at %0t: o_%s_rdata = %h, expected %h",
                     $time, port_name(p), dut_rdata[p], exp_dat[2][p]);
        end
    end
endtask

// One falling edge: check what is due, shift, apply the write, queue reads, drive
task automatic run_cycle();
    @(negedge cclk);
    for (int p = 0; p < STM_RPORTS; p++) begin
        check_port(p);
        exp_vld[2][p] = exp_vld[1][p];
        exp_dat[2][p] = exp_dat[1][p];
        exp_vld[1][p] = exp_vld[0][p];
        exp_dat[1][p] = exp_dat[0][p];
    end
    if (req_wen) begin
        model_write(req_waddr, req_wmask, req_wdata);   // Same-cycle read sees it
    end
    for (int p = 0; p < STM_RPORTS; p++) begin
        exp_vld[0][p] = req_ren[p];
        exp_dat[0][p] = req_ren[p] ? expected_payload(p, req_addr[p]) : '0;
    end
    drive_inputs();
    clear_request();
endtask

task automatic test_idle();
    repeat (IDLE_CYCLES) run_cycle();       // All valids expected low
endtask

task automatic test_fill();
    for (int b = 0; b < STM_BANKS; b++) begin
        for (int r = 0; r < STM_ROWS; r++) begin
            set_write(b, r, '1, random_row());
            run_cycle();
        end
    end
    repeat (DRAIN_CYCLES) run_cycle();
endtask

// Full-row write, then start 0 reads on every port
task automatic test_aligned();
    for (int b = 0; b < STM_BANKS; b++) begin
        set_write(b, 7 * b + 3, '1, random_row());
        run_cycle();
        for (int p = 0; p < STM_RPORTS; p++) set_read(p, b, 7 * b + 3, 0);
        run_cycle();
    end
    repeat (DRAIN_CYCLES) run_cycle();
endtask

task automatic test_rotated();
    int rows [3] = '{5, 62, 63};            // Row 63 wraps to row 0
    for (int b = 0; b < STM_BANKS; b++) begin
        for (int i = 0; i < 3; i++) begin
            for (int s = 1; s < STM_CHUNKS; s++) begin
                for (int p = 0; p < STM_RPORTS; p++) set_read(p, b, rows[i], s);
                run_cycle();
            end
        end
    end
    repeat (DRAIN_CYCLES) run_cycle();
endtask

task automatic test_masked();
    set_write(2, 20, 4'b1010, random_row());
    run_cycle();
    for (int p = 0; p < STM_RPORTS; p++) set_read(p, 2, 20, p);
    run_cycle();
    set_write(0, 63, 4'b0110, random_row());
    run_cycle();
    set_write(0, 0, 4'b0001, random_row());
    run_cycle();
    for (int p = 0; p < STM_RPORTS; p++) set_read(p, 0, 63, p);
    run_cycle();
    set_write(1, 9, 4'b0000, random_row()); // Empty mask, row stays as it was
    for (int p = 0; p < STM_RPORTS; p++) set_read(p, 1, 9, p);
    run_cycle();
    repeat (DRAIN_CYCLES) run_cycle();
endtask

// First half reads every port each cycle, second half leaves random gaps
task automatic test_back_to_back();
    for (int i = 0; i < B2B_CYCLES; i++) begin
        for (int p = 0; p < STM_RPORTS; p++) begin
            if (i < B2B_CYCLES / 2 || $urandom_range(3) != 0) begin
                req_ren[p]  = 1'b1;
                req_addr[p] = STM_ADDR_W'($urandom());
            end
        end
        if ($urandom_range(3) == 0) begin
            set_write(int'($urandom_range(STM_BANKS - 1)), int'($urandom_range(STM_ROWS - 1)),
                      STM_CHUNKS'($urandom()), random_row());
        end
        run_cycle();
    end
    repeat (DRAIN_CYCLES) run_cycle();
endtask

`endif

/* sim/stm_tb.sv */
// Testbench top for the shared table memory
// Clock, reset, DUT instance, reference model of the table, watchdog and report

`timescale 1ns/1ps

module stm_tb
    import stm_pkg::*;
();

    localparam int          CLK_PERIOD    = 40;             // ns
    localparam logic [31:0] SEED          = 32'hc0b8_5a7b;
    localparam int          RESET_CYCLES  = 3;
    localparam int          IDLE_CYCLES   = 8;
    localparam int          FILL_CYCLES   = STM_BANKS * STM_ROWS;     // One write per row
    localparam int          ALIGN_CYCLES  = 2 * STM_BANKS;            // Write then read, per bank
    localparam int          ROTATE_CYCLES = STM_BANKS * 3 * 3;        // Banks x rows x starts
    localparam int          MASK_CYCLES   = 6;
    localparam int          B2B_CYCLES    = 64;
    localparam int          DRAIN_CYCLES  = 4;                        // Pipeline flush per test
    localparam int          TEST_CYCLES   = RESET_CYCLES + IDLE_CYCLES + FILL_CYCLES
                                            + ALIGN_CYCLES + ROTATE_CYCLES + MASK_CYCLES
                                            + B2B_CYCLES + 6 * DRAIN_CYCLES;
    localparam int          MARGIN_CYCLES = 100;
    localparam int          WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic                   cclk;
    logic                   i_reset;
    logic                   i_lpm0_ren, i_em0_ren, i_lpm1_ren, i_em1_ren;
    logic [STM_ADDR_W-1:0]  i_lpm0_raddr, i_em0_raddr, i_lpm1_raddr, i_em1_raddr;
    logic                   o_lpm0_rvalid, o_em0_rvalid, o_lpm1_rvalid, o_em1_rvalid;
    lpm_data_t              o_lpm0_rdata, o_lpm1_rdata;
    em_data_t               o_em0_rdata, o_em1_rdata;
    logic                   i_wen;
    logic [STM_WADDR_W-1:0] i_waddr;
    logic [STM_CHUNKS-1:0]  i_wmask;
    row_data_t              i_wdata;

    // Outputs gathered per port, port order lpm0, em0, lpm1, em1
    logic [STM_RPORTS-1:0]  dut_rvalid;
    row_data_t              dut_rdata [STM_RPORTS];

    row_data_t              ref_mem [STM_BANKS][STM_ROWS];   // Reference copy of the table

    // Expected results in flight, stage 2 is due at the current falling edge
    logic                   exp_vld [3][STM_RPORTS];
    row_data_t              exp_dat [3][STM_RPORTS];

    // Request for the next cycle, set by the tests and driven by run_cycle
    logic                   req_ren  [STM_RPORTS];
    logic [STM_ADDR_W-1:0]  req_addr [STM_RPORTS];
    logic                   req_wen;
    logic [STM_WADDR_W-1:0] req_waddr;
    logic [STM_CHUNKS-1:0]  req_wmask;
    row_data_t              req_wdata;

    int                     errors = 0;
    int                     checks = 0;

    assign dut_rvalid   = {o_em1_rvalid, o_lpm1_rvalid, o_em0_rvalid, o_lpm0_rvalid};
    assign dut_rdata[0] = {32'h0, o_lpm0_rdata};    // LPM upper chunks read as zero
    assign dut_rdata[1] = o_em0_rdata;
    assign dut_rdata[2] = {32'h0, o_lpm1_rdata};
    assign dut_rdata[3] = o_em1_rdata;

    stm_top stm_top_inst (.*);

    `include "stm_tb_tasks.svh"

    initial begin
        cclk = 1'b0;
        forever #(CLK_PERIOD / 2) cclk = ~cclk;
    end

    // Ends a run that stalls past the expected test length
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d cycles, tests did not finish",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clear_request();
        clear_pipeline();
        drive_inputs();
        i_reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge cclk);
        i_reset = 1'b0;

        test_idle();
        test_fill();
        test_aligned();
        test_rotated();
        test_masked();
        test_back_to_back();

        $display("Closing report: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* stm_top.f */
+incdir+include
design/stm_pkg.sv
design/stm_rd_if.sv
design/stm_decode.sv
design/stm_execute.sv
design/stm_result.sv
design/stm_top.sv
sim/stm_tb.sv

/* Makefile */
# Verilator build and run for the shared table memory testbench

TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := stm_tb
FILELIST := stm_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The pass line in the log decides the exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
